//--- soc_pkg.sv
package soc_pkg;

    ////////////////////
    // address map
    ////////////////////

    localparam logic [3:0] REGION_SRAM  = 4'h0;
    localparam logic [3:0] REGION_TIMER = 4'h2;
    localparam logic [3:0] REGION_GPIO  = 4'h4;

    // timer register indices
    localparam logic [1:0] TMR_CTRL  = 2'd0;
    localparam logic [1:0] TMR_COUNT = 2'd1;
    localparam logic [1:0] TMR_VALUE = 2'd2;

    // gpio register indices
    localparam logic [1:0] GPIO_CTRL = 2'd0;
    localparam logic [1:0] GPIO_DATA = 2'd1;

    ////////////////////
    // bus types
    ////////////////////

    // sram sees a word index, peripherals see a register index
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [25:0] word_idx;
            logic [1:0]  byte_off;
        } mem;
        struct packed {
            logic [3:0]  region;
            logic [23:0] unused;
            logic [1:0]  reg_idx;
            logic [1:0]  byte_off;
        } regs;
    } bus_addr_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  wem;
        bus_addr_t   addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        data_ok;
        logic [31:0] rdata;
    } slave_rsp_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_TIMER,
        SEL_GPIO,
        SEL_NONE
    } slave_sel_t;

    // byte-masked update of a 32-bit register
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  wem
    );
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (wem[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
    input  soc_pkg::bus_req_t   req_i,
    output logic                sram_sel_o,
    output logic                timer_sel_o,
    output logic                gpio_sel_o,
    output soc_pkg::slave_sel_t sel_o,
    output logic                addr_ok_o
);
    import soc_pkg::*;

    logic [3:0] region;

    // both union views share the region field
    assign region = req_i.addr.mem.region;

    always_comb begin
        case (region)
            REGION_SRAM:  sel_o = SEL_SRAM;
            REGION_TIMER: sel_o = SEL_TIMER;
            REGION_GPIO:  sel_o = SEL_GPIO;
            default:      sel_o = SEL_NONE;
        endcase
    end

    // one strobe at most, only while req is up
    assign sram_sel_o  = req_i.req && (sel_o == SEL_SRAM);
    assign timer_sel_o = req_i.req && (sel_o == SEL_TIMER);
    assign gpio_sel_o  = req_i.req && (sel_o == SEL_GPIO);

    // no back-pressure, unmapped regions are accepted too
    assign addr_ok_o = req_i.req;

endmodule

//--- sram_slave.sv
`timescale 1ns/10ps

module sram_slave #(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel_i,
    input  soc_pkg::bus_req_t   req_i,
    output soc_pkg::slave_rsp_t rsp_o
);
    import soc_pkg::*;

    localparam int unsigned AW = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

    logic [31:0]   mem_q [SRAM_WORDS];
    logic [AW-1:0] idx;
    logic [31:0]   rdata_q;
    logic          data_ok_q;

    // addresses alias modulo the depth
    assign idx = AW'(req_i.addr.mem.word_idx % SRAM_WORDS);

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (sel_i) begin
            // read-first, old word goes back
            rdata_q <= mem_q[idx];
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.wem[b]) begin
                        mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sel_i;
        end
    end

    assign rsp_o.data_ok = data_ok_q;
    assign rsp_o.rdata   = rdata_q;

endmodule

//--- timer_slave.sv
`timescale 1ns/10ps

module timer_slave (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel_i,
    input  soc_pkg::bus_req_t   req_i,
    output soc_pkg::slave_rsp_t rsp_o,
    output logic                irq_o
);
    import soc_pkg::*;

    logic        enable_q;
    logic        irq_en_q;
    logic        pending_q;
    logic [31:0] count_q;
    logic [31:0] value_q;
    logic        irq_q;
    logic [31:0] rdata_q;
    logic        data_ok_q;
    logic [1:0]  reg_idx;
    logic        wr_ctrl;
    logic        wr_value;
    logic        hit;

    assign reg_idx  = req_i.addr.regs.reg_idx;
    assign wr_ctrl  = sel_i && req_i.we && (reg_idx == TMR_CTRL);
    assign wr_value = sel_i && req_i.we && (reg_idx == TMR_VALUE);
    assign hit      = enable_q && (count_q == value_q);

    ////////////////////
    // counter and irq
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            pending_q <= 1'b0;
            count_q   <= '0;
            value_q   <= '0;
            irq_q     <= 1'b0;
        end else begin
            if (hit) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 32'd1;
            end
            // a new match wins over a clear in the same cycle
            if (hit) begin
                pending_q <= 1'b1;
            end else if (wr_ctrl && req_i.wem[0] && req_i.wdata[2]) begin
                pending_q <= 1'b0;
            end
            if (wr_ctrl && req_i.wem[0]) begin
                enable_q <= req_i.wdata[0];
                irq_en_q <= req_i.wdata[1];
            end
            if (wr_value) begin
                value_q <= merge_bytes(value_q, req_i.wdata, req_i.wem);
            end
            irq_q <= pending_q && irq_en_q;
        end
    end

    ////////////////////
    // read port
    ////////////////////

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (reg_idx)
                TMR_CTRL:  rdata_q <= {29'd0, pending_q, irq_en_q, enable_q};
                TMR_COUNT: rdata_q <= count_q;
                TMR_VALUE: rdata_q <= value_q;
                default:   rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sel_i;
        end
    end

    assign rsp_o.data_ok = data_ok_q;
    assign rsp_o.rdata   = rdata_q;
    assign irq_o         = irq_q;

endmodule

//--- gpio_slave.sv
`timescale 1ns/10ps

module gpio_slave #(
    parameter int unsigned GPIO_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel_i,
    input  soc_pkg::bus_req_t     req_i,
    output soc_pkg::slave_rsp_t   rsp_o,
    input  logic [GPIO_WIDTH-1:0] pin_i,
    output logic [GPIO_WIDTH-1:0] pin_oe_o,
    output logic [GPIO_WIDTH-1:0] pin_o
);
    import soc_pkg::*;

    logic [2*GPIO_WIDTH-1:0] ctrl_q;
    logic [GPIO_WIDTH-1:0]   data_q;
    logic [GPIO_WIDTH-1:0]   pin_meta_q;
    logic [GPIO_WIDTH-1:0]   pin_sync_q;
    logic [31:0]             rdata_q;
    logic                    data_ok_q;
    logic [31:0]             ctrl_new;
    logic [31:0]             data_new;
    logic [1:0]              reg_idx;

    assign reg_idx  = req_i.addr.regs.reg_idx;
    assign ctrl_new = merge_bytes(32'(ctrl_q), req_i.wdata, req_i.wem);
    assign data_new = merge_bytes(32'(data_q), req_i.wdata, req_i.wem);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q    <= '0;
            data_q    <= '0;
            data_ok_q <= 1'b0;
        end else begin
            if (sel_i && req_i.we && (reg_idx == GPIO_CTRL)) begin
                ctrl_q <= ctrl_new[2*GPIO_WIDTH-1:0];
            end
            if (sel_i && req_i.we && (reg_idx == GPIO_DATA)) begin
                data_q <= data_new[GPIO_WIDTH-1:0];
            end
            data_ok_q <= sel_i;
        end
    end

    // two-flop synchroniser on the pins
    always_ff @(posedge clk) begin
        pin_meta_q <= pin_i;
        pin_sync_q <= pin_meta_q;
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (reg_idx)
                GPIO_CTRL: rdata_q <= 32'(ctrl_q);
                GPIO_DATA: rdata_q <= 32'(pin_sync_q);
                default:   rdata_q <= '0;
            endcase
        end
    end

    // code 01 drives the pin
    always_comb begin
        for (int i = 0; i < GPIO_WIDTH; i++) begin
            pin_oe_o[i] = (ctrl_q[2*i +: 2] == 2'b01);
        end
    end

    assign pin_o         = data_q;
    assign rsp_o.data_ok = data_ok_q;
    assign rsp_o.rdata   = rdata_q;

endmodule

//--- bus_response.sv
`timescale 1ns/10ps

module bus_response (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                accept_i,
    input  soc_pkg::slave_sel_t sel_i,
    input  soc_pkg::slave_rsp_t sram_rsp_i,
    input  soc_pkg::slave_rsp_t timer_rsp_i,
    input  soc_pkg::slave_rsp_t gpio_rsp_i,
    output soc_pkg::bus_rsp_t   rsp_o
);
    import soc_pkg::*;

    slave_sel_t sel_q;
    logic       pend_q;

    // which slave owns the response cycle
    always_ff @(posedge clk) begin
        if (accept_i) begin
            sel_q <= sel_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= accept_i;
        end
    end

    always_comb begin
        // addr_ok comes from the decoder in soc_top
        rsp_o.addr_ok = 1'b0;
        case (sel_q)
            SEL_SRAM: begin
                rsp_o.data_ok = pend_q && sram_rsp_i.data_ok;
                rsp_o.rdata   = sram_rsp_i.rdata;
            end
            SEL_TIMER: begin
                rsp_o.data_ok = pend_q && timer_rsp_i.data_ok;
                rsp_o.rdata   = timer_rsp_i.rdata;
            end
            SEL_GPIO: begin
                rsp_o.data_ok = pend_q && gpio_rsp_i.data_ok;
                rsp_o.rdata   = gpio_rsp_i.rdata;
            end
            default: begin
                // unmapped, completes here with zero data
                rsp_o.data_ok = pend_q;
                rsp_o.rdata   = '0;
            end
        endcase
    end

endmodule

//--- soc_top.sv
`timescale 1ns/10ps

module soc_top #(
    parameter int unsigned SRAM_WORDS = 1024,
    parameter int unsigned GPIO_WIDTH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  soc_pkg::bus_req_t   bus_req_i,
    output soc_pkg::bus_rsp_t   bus_rsp_o,
    output logic                timer_irq_o,
    inout  wire [GPIO_WIDTH-1:0] gpio_io
);
    import soc_pkg::*;

    logic                  sram_sel;
    logic                  timer_sel;
    logic                  gpio_sel;
    slave_sel_t            sel;
    logic                  addr_ok;
    logic                  accept;
    slave_rsp_t            sram_rsp;
    slave_rsp_t            timer_rsp;
    slave_rsp_t            gpio_rsp;
    bus_rsp_t              resp;
    logic [GPIO_WIDTH-1:0] pin_in;
    logic [GPIO_WIDTH-1:0] pin_oe;
    logic [GPIO_WIDTH-1:0] pin_out;

    ////////////////////
    // decode
    ////////////////////

    bus_decode u_decode (
        .req_i       (bus_req_i),
        .sram_sel_o  (sram_sel),
        .timer_sel_o (timer_sel),
        .gpio_sel_o  (gpio_sel),
        .sel_o       (sel),
        .addr_ok_o   (addr_ok)
    );

    assign accept = bus_req_i.req && addr_ok;

    ////////////////////
    // slaves
    ////////////////////

    sram_slave #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .sel_i (sram_sel),
        .req_i (bus_req_i),
        .rsp_o (sram_rsp)
    );

    timer_slave u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .sel_i (timer_sel),
        .req_i (bus_req_i),
        .rsp_o (timer_rsp),
        .irq_o (timer_irq_o)
    );

    gpio_slave #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel_i    (gpio_sel),
        .req_i    (bus_req_i),
        .rsp_o    (gpio_rsp),
        .pin_i    (pin_in),
        .pin_oe_o (pin_oe),
        .pin_o    (pin_out)
    );

    ////////////////////
    // response
    ////////////////////

    bus_response u_resp (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept_i    (accept),
        .sel_i       (sel),
        .sram_rsp_i  (sram_rsp),
        .timer_rsp_i (timer_rsp),
        .gpio_rsp_i  (gpio_rsp),
        .rsp_o       (resp)
    );

    assign bus_rsp_o.addr_ok = addr_ok;
    assign bus_rsp_o.data_ok = resp.data_ok;
    assign bus_rsp_o.rdata   = resp.rdata;

    // tri-state pads, inputs float when not driven
    for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
        assign gpio_io[i] = pin_oe[i] ? pin_out[i] : 1'bz;
    end

    assign pin_in = gpio_io;

endmodule

//--- tb_soc_top.sv
`timescale 1ns/10ps

module tb_soc_top;
    import soc_pkg::*;

    localparam int unsigned SRAM_WORDS = 64;
    localparam int unsigned GPIO_WIDTH = 2;
    localparam int unsigned SRAM_TESTS = 48;
    localparam int unsigned TMR_LIMIT  = 10;
    // about one cycle per access, plus timer waits, pin waits and slack
    localparam int unsigned TIMEOUT_CYCLES =
        2 * (2 * SRAM_TESTS + 30) + 3 * (TMR_LIMIT + 4) + 100;

    logic                  clk;
    logic                  rst_n;
    bus_req_t              bus_req;
    bus_rsp_t              bus_rsp;
    logic                  timer_irq;
    wire  [GPIO_WIDTH-1:0] gpio_w;
    logic [GPIO_WIDTH-1:0] pin_level;
    logic [31:0]           ref_mem [SRAM_WORDS];
    logic [31:0]           lfsr = 32'hf0a8;
    int unsigned           errors = 0;
    int unsigned           cycles = 0;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    soc_top #(
        .SRAM_WORDS (SRAM_WORDS),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_rsp_o   (bus_rsp),
        .timer_irq_o (timer_irq),
        .gpio_io     (gpio_w)
    );

    // external pulls, any driven pin overrides them
    assign (weak0, weak1) gpio_w = pin_level;

    ////////////////////
    // handshake checks
    ////////////////////

    addr_ok_follows_req: assert property (@(posedge clk) bus_rsp.addr_ok == bus_req.req)
    else begin
        errors++;
        $display("[ERROR] %0t addr_ok expected %b got %b",
                 $time, $sampled(bus_req.req), $sampled(bus_rsp.addr_ok));
    end

    data_ok_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.req && bus_rsp.addr_ok |=> bus_rsp.data_ok)
    else begin
        errors++;
        $display("[ERROR] %0t data_ok expected 1 got %b", $time, $sampled(bus_rsp.data_ok));
    end

    no_stray_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_req.req && bus_rsp.addr_ok) |=> !bus_rsp.data_ok)
    else begin
        errors++;
        $display("[ERROR] %0t data_ok expected 0 got %b", $time, $sampled(bus_rsp.data_ok));
    end

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !bus_rsp.data_ok && !timer_irq)
    else begin
        errors++;
        $display("[ERROR] %0t data_ok/timer_irq_o expected 0/0 got %b/%b",
                 $time, $sampled(bus_rsp.data_ok), $sampled(timer_irq));
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_lfsr_bit()};
        end
        return r;
    endfunction

    function automatic bus_addr_t sram_addr(input logic [25:0] word);
        bus_addr_t a;
        a              = '0;
        a.mem.region   = REGION_SRAM;
        a.mem.word_idx = word;
        return a;
    endfunction

    function automatic bus_addr_t reg_addr(input logic [3:0] region, input logic [1:0] idx);
        bus_addr_t a;
        a              = '0;
        a.regs.region  = region;
        a.regs.reg_idx = idx;
        return a;
    endfunction

    // starts and ends on a falling edge, so calls run back to back
    task automatic bus_access(input logic we, input logic [3:0] wem, input bus_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        bus_req.req   = 1'b1;
        bus_req.we    = we;
        bus_req.wem   = wem;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        @(posedge clk);
        while (!bus_rsp.addr_ok) begin
            @(posedge clk);
        end
        @(negedge clk);
        bus_req.req = 1'b0;
        while (!bus_rsp.data_ok) begin
            @(negedge clk);
        end
        rdata = bus_rsp.rdata;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the bus stopped responding", cycles);
            $display("Run finished with %0d errors", errors);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic [31:0] rdata;
        logic [7:0]  idx;
        logic [3:0]  wem;
        logic [31:0] wdata;
        int unsigned w;
        int unsigned n;
        bus_addr_t   a;
        logic        drive_lvl;

        rst_n     = 1'b0;
        bus_req   = '0;
        pin_level = 2'b10;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // nothing drives the pads yet
        check_value("gpio_io", 32'(pin_level), 32'(gpio_w));

        // random masked writes, each read back through an alias
        for (int t = 0; t < SRAM_TESTS; t++) begin
            idx   = 8'(rand_bits(8));
            wem   = 4'(rand_bits(4));
            wdata = rand_bits(32);
            w     = idx % SRAM_WORDS;
            bus_access(1'b1, wem, sram_addr(26'(idx)), wdata, rdata);
            check_value("bus_rsp_o.rdata", ref_mem[w], rdata);
            for (int b = 0; b < 4; b++) begin
                if (wem[b]) begin
                    ref_mem[w][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            bus_access(1'b0, 4'h0, sram_addr(26'(w + SRAM_WORDS * rand_bits(2))), '0, rdata);
            check_value("bus_rsp_o.rdata", ref_mem[w], rdata);
        end
        repeat (2) @(negedge clk);

        // unmapped regions read zero and drop writes
        bus_access(1'b1, 4'hf, sram_addr(26'd5), 32'h5a5a_0f0f, rdata);
        ref_mem[5] = 32'h5a5a_0f0f;
        a = sram_addr(26'd5);
        a.mem.region = 4'h9;
        bus_access(1'b1, 4'hf, a, rand_bits(32), rdata);
        check_value("bus_rsp_o.rdata", 32'h0, rdata);
        a.mem.region = 4'h7;
        bus_access(1'b0, 4'h0, a, '0, rdata);
        check_value("bus_rsp_o.rdata", 32'h0, rdata);
        bus_access(1'b0, 4'h0, sram_addr(26'd5), '0, rdata);
        check_value("bus_rsp_o.rdata", ref_mem[5], rdata);

        // timer with both enables
        bus_access(1'b1, 4'hf, reg_addr(REGION_TIMER, TMR_VALUE), 32'(TMR_LIMIT), rdata);
        bus_access(1'b1, 4'h1, reg_addr(REGION_TIMER, TMR_CTRL), 32'h3, rdata);
        n = 0;
        while (!timer_irq && n < TMR_LIMIT + 3) begin
            @(negedge clk);
            n++;
        end
        check_value("timer_irq_o", 32'h1, 32'(timer_irq));
        // clear pending and stop, irq enable stays on
        bus_access(1'b1, 4'h1, reg_addr(REGION_TIMER, TMR_CTRL), 32'h6, rdata);
        @(negedge clk);
        check_value("timer_irq_o", 32'h0, 32'(timer_irq));
        bus_access(1'b0, 4'h0, reg_addr(REGION_TIMER, TMR_CTRL), '0, rdata);
        check_value("bus_rsp_o.rdata", 32'h2, rdata);

        // counting without irq enable, pending still sets
        bus_access(1'b1, 4'h1, reg_addr(REGION_TIMER, TMR_CTRL), 32'h1, rdata);
        repeat (TMR_LIMIT + 4) begin
            @(negedge clk);
            check_value("timer_irq_o", 32'h0, 32'(timer_irq));
        end
        bus_access(1'b0, 4'h0, reg_addr(REGION_TIMER, TMR_CTRL), '0, rdata);
        check_value("bus_rsp_o.rdata", 32'h5, rdata);
        bus_access(1'b1, 4'h1, reg_addr(REGION_TIMER, TMR_CTRL), 32'h4, rdata);

        // gpio inputs out of reset
        bus_access(1'b0, 4'h0, reg_addr(REGION_GPIO, GPIO_CTRL), '0, rdata);
        check_value("bus_rsp_o.rdata", 32'h0, rdata);
        bus_access(1'b0, 4'h0, reg_addr(REGION_GPIO, GPIO_DATA), '0, rdata);
        check_value("bus_rsp_o.rdata", 32'(pin_level), rdata);

        // pin 0 drives against its pull, pin 1 stays an input
        drive_lvl = ~pin_level[0];
        bus_access(1'b1, 4'h1, reg_addr(REGION_GPIO, GPIO_CTRL), 32'h1, rdata);
        bus_access(1'b1, 4'h1, reg_addr(REGION_GPIO, GPIO_DATA), 32'(drive_lvl), rdata);
        check_value("gpio_io[0]", 32'(drive_lvl), 32'(gpio_w[0]));
        for (int k = 0; k < 4; k++) begin
            pin_level = 2'(rand_bits(2));
            repeat (3) @(negedge clk);
            bus_access(1'b0, 4'h0, reg_addr(REGION_GPIO, GPIO_DATA), '0, rdata);
            check_value("bus_rsp_o.rdata", {30'd0, pin_level[1], drive_lvl}, rdata);
            check_value("gpio_io[0]", 32'(drive_lvl), 32'(gpio_w[0]));
        end

        repeat (2) @(negedge clk);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sources.f
soc_pkg.sv
bus_decode.sv
sram_slave.sv
timer_slave.sv
gpio_slave.sv
bus_response.sv
soc_top.sv
tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_periph

dependencies: {}

sources:
  - soc_pkg.sv
  - bus_decode.sv
  - sram_slave.sv
  - timer_slave.sv
  - gpio_slave.sv
  - bus_response.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_top.sv
